// File: source/aes_pkg.sv
package aes_pkg;

    typedef logic [0:127]  block_t;
    typedef logic [0:127]  round_key_t;
    typedef logic [0:1407] key_schedule_t;  // round key 0 first
    typedef logic [0:127]  key_t;

    localparam int NUM_ROUNDS = 10;

    // ------------------------------------------------------------------------
    // forward S-box, byte i at bits [8*i +: 8]
    // ------------------------------------------------------------------------
    localparam logic [0:2047] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] fn_sbox(input logic [7:0] x);
        return SBOX[8 * int'(x) +: 8];
    endfunction

    function automatic logic [7:0] fn_xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // multiply by 2 in GF(2^8)
    endfunction

    function automatic logic [7:0] fn_rcon(input int round);
        case (round)
            1:       return 8'h01;
            2:       return 8'h02;
            3:       return 8'h04;
            4:       return 8'h08;
            5:       return 8'h10;
            6:       return 8'h20;
            7:       return 8'h40;
            8:       return 8'h80;
            9:       return 8'h1b;
            default: return 8'h36;
        endcase
    endfunction

    function automatic round_key_t fn_round_key(input key_schedule_t sched, input int round);
        return sched[128 * round +: 128];
    endfunction

    // ------------------------------------------------------------------------
    // round building blocks, state bytes in column order
    // ------------------------------------------------------------------------
    function automatic block_t fn_sub_bytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++)
        begin
            r[8 * i +: 8] = fn_sbox(s[8 * i +: 8]);
        end
        return r;
    endfunction

    function automatic block_t fn_shift_rows(input block_t s);
        block_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int w = 0; w < 4; w++)
            begin
                r[8 * (4 * c + w) +: 8] = s[8 * (4 * ((c + w) % 4) + w) +: 8];  // row w left by w
            end
        end
        return r;
    endfunction

    function automatic block_t fn_mix_columns(input block_t s);
        block_t     r;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        for (int c = 0; c < 4; c++)
        begin
            b0 = s[32 * c      +: 8];
            b1 = s[32 * c + 8  +: 8];
            b2 = s[32 * c + 16 +: 8];
            b3 = s[32 * c + 24 +: 8];
            r[32 * c      +: 8] = fn_xtime(b0) ^ fn_xtime(b1) ^ b1 ^ b2 ^ b3;
            r[32 * c + 8  +: 8] = b0 ^ fn_xtime(b1) ^ fn_xtime(b2) ^ b2 ^ b3;
            r[32 * c + 16 +: 8] = b0 ^ b1 ^ fn_xtime(b2) ^ fn_xtime(b3) ^ b3;
            r[32 * c + 24 +: 8] = fn_xtime(b0) ^ b0 ^ b1 ^ b2 ^ fn_xtime(b3);
        end
        return r;
    endfunction

    // next round key from the previous one
    function automatic round_key_t fn_key_step(input round_key_t prev, input logic [7:0] rcon);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [31:0] t;
        w0 = prev[0  +: 32];
        w1 = prev[32 +: 32];
        w2 = prev[64 +: 32];
        w3 = prev[96 +: 32];
        t  = {w3[23:0], w3[31:24]};  // RotWord
        t  = {fn_sbox(t[31:24]), fn_sbox(t[23:16]), fn_sbox(t[15:8]), fn_sbox(t[7:0])};
        t  = t ^ {rcon, 24'h000000};
        w0 = w0 ^ t;
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        return {w0, w1, w2, w3};
    endfunction

    // one full round, round 1 folds in the initial AddRoundKey
    function automatic block_t fn_aes_round(input block_t blk, input int round,
                                            input key_schedule_t sched);
        block_t s;
        s = blk;
        if (round == 1)
        begin
            s = s ^ fn_round_key(sched, 0);
        end
        s = fn_shift_rows(fn_sub_bytes(s));
        if (round != NUM_ROUNDS)
        begin
            s = fn_mix_columns(s);
        end
        return s ^ fn_round_key(sched, round);
    endfunction

endpackage

// File: source/gcm_pkg.sv
package gcm_pkg;

    typedef logic [0:95] iv_t;    // 96-bit IV, J0 = IV || ctr
    typedef logic [31:0] ctr32_t;  // low word of the counter block

    localparam ctr32_t CTR_J0       = 32'd1;
    localparam ctr32_t CTR_CB_FIRST = 32'd2;

    // ------------------------------------------------------------------------
    // block kind, travels with every block through the pipeline
    // ------------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        BLK_H,
        BLK_J0,
        BLK_CB
    } blk_kind_t;

    // ------------------------------------------------------------------------
    // precompute controller states
    // ------------------------------------------------------------------------
    typedef enum logic [2:0]
    {
        IDLE,
        EXPAND,
        ISSUE_H,
        ISSUE_J0,
        ISSUE_CB,
        ACK
    } ctrl_state_t;

endpackage

// File: source/aes_key_expand.sv
`timescale 1ns/1ns

module aes_key_expand
    import aes_pkg::*;
(
    input  logic          clk,
    input  logic          i_arst_n,
    input  logic          i_start,
    input  key_t          i_key,
    output logic          o_done,
    output key_schedule_t o_schedule
);

    logic       busy;
    logic [3:0] rnd;       // round key being derived, 1 to 10
    round_key_t prev_key;  // last key written into the schedule
    round_key_t next_key;

    assign next_key = fn_key_step(prev_key, fn_rcon(int'(rnd)));

    // ------------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            busy   <= 1'b0;
            rnd    <= '0;
            o_done <= 1'b0;
        end
        else if (i_start)
        begin
            busy   <= 1'b1;
            rnd    <= 4'd1;
            o_done <= 1'b0;  // schedule invalid until round 10 lands
        end
        else if (busy)
        begin
            rnd <= rnd + 4'd1;
            if (rnd == 4'(NUM_ROUNDS))
            begin
                busy   <= 1'b0;
                o_done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // key storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            prev_key          <= i_key;
            o_schedule[0 +: 128] <= i_key;  // round key 0 is the cipher key
        end
        else if (busy)
        begin
            prev_key                    <= next_key;
            o_schedule[128 * rnd +: 128] <= next_key;
        end
    end

endmodule

// File: source/aes_round_stage.sv
`timescale 1ns/1ns

module aes_round_stage
    import aes_pkg::*;
    import gcm_pkg::*;
#(
    parameter int ROUND = 1
)
(
    input  logic          clk,
    input  logic          i_arst_n,
    input  logic          i_valid,
    input  blk_kind_t     i_kind,
    input  block_t        i_block,
    input  key_schedule_t i_schedule,
    output logic          o_valid,
    output blk_kind_t     o_kind,
    output block_t        o_block,
    output key_schedule_t o_schedule
);

    logic          r_valid;
    blk_kind_t     r_kind;
    block_t        r_block;
    key_schedule_t r_schedule;

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_valid <= 1'b0;
        end
        else
        begin
            r_valid <= i_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        r_kind     <= i_kind;
        r_block    <= i_block;
        r_schedule <= i_schedule;  // schedule of the block's own instance
    end

    // round logic sits after the register
    always_comb
    begin
        o_block    = fn_aes_round(r_block, ROUND, r_schedule);
        o_valid    = r_valid;
        o_kind     = r_kind;
        o_schedule = r_schedule;
    end

endmodule

// File: source/gcm_block_counter.sv
`timescale 1ns/1ns

module gcm_block_counter
    import aes_pkg::*;
    import gcm_pkg::*;
#(
    parameter int CTR_W = 8
)
(
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_load,
    input  logic             i_step,
    input  iv_t              i_iv,
    input  logic [CTR_W-1:0] i_num_blocks,
    output block_t           o_block_j0,
    output block_t           o_block_cb,
    output logic             o_remaining_zero
);

    iv_t              r_iv;
    ctr32_t           r_ctr;        // counter of the next CB block
    logic [CTR_W-1:0] r_remaining;  // CB blocks still to issue

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_ctr       <= CTR_CB_FIRST;
            r_remaining <= '0;
        end
        else if (i_load)
        begin
            r_ctr       <= CTR_CB_FIRST;
            r_remaining <= i_num_blocks;
        end
        else if (i_step)
        begin
            r_ctr       <= r_ctr + 32'd1;  // wraps mod 2^32, IV untouched
            r_remaining <= r_remaining - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_load)
        begin
            r_iv <= i_iv;
        end
    end

    assign o_block_j0       = {r_iv, CTR_J0};
    assign o_block_cb       = {r_iv, r_ctr};
    assign o_remaining_zero = (r_remaining == '0);

endmodule

// File: source/gcm_precompute_ctrl.sv
`timescale 1ns/1ns

module gcm_precompute_ctrl
    import gcm_pkg::*;
#(
    parameter int CTR_W = 8
)
(
    input  logic      clk,
    input  logic      i_arst_n,
    input  logic      i_req,
    input  logic      i_kx_done,
    input  logic      i_remaining_zero,
    output logic      o_ack,
    output logic      o_kx_start,
    output logic      o_load,
    output logic      o_step,
    output logic      o_issue_valid,
    output blk_kind_t o_issue_kind
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // next state and outputs
    // ------------------------------------------------------------------------
    always_comb
    begin
        state_nxt     = state;
        o_ack         = 1'b0;
        o_kx_start    = 1'b0;
        o_load        = 1'b0;
        o_step        = 1'b0;
        o_issue_valid = 1'b0;
        o_issue_kind  = BLK_H;
        case (state)
            IDLE:
            begin
                if (i_req)  // ack is always low here
                begin
                    o_kx_start = 1'b1;
                    o_load     = 1'b1;
                    state_nxt  = EXPAND;
                end
            end
            EXPAND:
            begin
                if (i_kx_done)
                begin
                    state_nxt = ISSUE_H;
                end
            end
            ISSUE_H:
            begin
                o_issue_valid = 1'b1;
                state_nxt     = ISSUE_J0;
            end
            ISSUE_J0:
            begin
                o_issue_valid = 1'b1;
                o_issue_kind  = BLK_J0;
                state_nxt     = ISSUE_CB;
            end
            ISSUE_CB:
            begin
                // count exhausted means the previous cycle issued the last block
                if (i_remaining_zero)
                begin
                    o_ack     = 1'b1;
                    state_nxt = ACK;
                end
                else
                begin
                    o_issue_valid = 1'b1;
                    o_issue_kind  = BLK_CB;
                    o_step        = 1'b1;
                end
            end
            ACK:
            begin
                o_ack = 1'b1;
                if (!i_req)
                begin
                    state_nxt = IDLE;  // ack drops one cycle later
                end
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

// File: source/gcm_precompute_top.sv
`timescale 1ns/1ns

module gcm_precompute_top
    import aes_pkg::*;
    import gcm_pkg::*;
#(
    parameter int CTR_W = 8
)
(
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_req,
    input  key_t             i_key,
    input  iv_t              i_iv,
    input  logic [CTR_W-1:0] i_num_blocks,
    output logic             o_ack,
    output logic             o_valid,
    output blk_kind_t        o_kind,
    output block_t           o_block
);

    logic          kx_start;
    logic          kx_done;
    logic          load;
    logic          step;
    logic          remaining_zero;
    logic          issue_valid;
    blk_kind_t     issue_kind;
    key_schedule_t schedule;
    block_t        block_j0;
    block_t        block_cb;
    block_t        issue_block;

    // index 0 is the pipeline input, index g the output of stage g
    logic          stage_valid [0:NUM_ROUNDS];
    blk_kind_t     stage_kind  [0:NUM_ROUNDS];
    block_t        stage_block [0:NUM_ROUNDS];
    key_schedule_t stage_sched [0:NUM_ROUNDS];

    gcm_precompute_ctrl #(
        .CTR_W            (CTR_W)
    ) u_ctrl (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_req            (i_req),
        .i_kx_done        (kx_done),
        .i_remaining_zero (remaining_zero),
        .o_ack            (o_ack),
        .o_kx_start       (kx_start),
        .o_load           (load),
        .o_step           (step),
        .o_issue_valid    (issue_valid),
        .o_issue_kind     (issue_kind)
    );

    gcm_block_counter #(
        .CTR_W            (CTR_W)
    ) u_counter (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_load           (load),
        .i_step           (step),
        .i_iv             (i_iv),
        .i_num_blocks     (i_num_blocks),
        .o_block_j0       (block_j0),
        .o_block_cb       (block_cb),
        .o_remaining_zero (remaining_zero)
    );

    aes_key_expand u_key_expand (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_start    (kx_start),
        .i_key      (i_key),
        .o_done     (kx_done),
        .o_schedule (schedule)
    );

    // ------------------------------------------------------------------------
    // stage 1 input select
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (issue_kind)
            BLK_J0:  issue_block = block_j0;
            BLK_CB:  issue_block = block_cb;
            default: issue_block = '0;  // H = E(K, 0^128)
        endcase
    end

    assign stage_valid[0] = issue_valid;
    assign stage_kind[0]  = issue_kind;
    assign stage_block[0] = issue_block;
    assign stage_sched[0] = schedule;

    for (genvar g = 1; g <= NUM_ROUNDS; g++)
    begin : g_round
        aes_round_stage #(
            .ROUND      (g)
        ) u_stage (
            .clk        (clk),
            .i_arst_n   (i_arst_n),
            .i_valid    (stage_valid[g-1]),
            .i_kind     (stage_kind[g-1]),
            .i_block    (stage_block[g-1]),
            .i_schedule (stage_sched[g-1]),
            .o_valid    (stage_valid[g]),
            .o_kind     (stage_kind[g]),
            .o_block    (stage_block[g]),
            .o_schedule (stage_sched[g])
        );
    end

    assign o_valid = stage_valid[NUM_ROUNDS];
    assign o_kind  = stage_kind[NUM_ROUNDS];
    assign o_block = stage_block[NUM_ROUNDS];

endmodule

// File: test/tb_gcm_precompute.sv
`timescale 1ns/1ns

module tb_gcm_precompute
    import aes_pkg::*;
    import gcm_pkg::*;
();

    localparam int     CTR_W          = 8;
    localparam int     NUM_INSTANCES  = 11;
    localparam int     TIMEOUT_CYCLES = 64 * NUM_INSTANCES + 100;
    localparam block_t KAT_H          = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam block_t KAT_J0         = 128'h58e2fccefa7e3061367f1d57a4e7455a;
    localparam block_t KAT_CB2        = 128'h0388dace60b6a392f328c2b971b2fe78;

    logic             clk;
    logic             i_arst_n;
    logic             i_req;
    key_t             i_key;
    iv_t              i_iv;
    logic [CTR_W-1:0] i_num_blocks;
    logic             o_ack;
    logic             o_valid;
    blk_kind_t        o_kind;
    block_t           o_block;

    blk_kind_t exp_kind_q [$];   // one entry per block still to come
    block_t    exp_block_q [$];
    bit        exp_any_q [$];    // value not known, kind only
    bit        exp_last_q [$];   // last block of its instance

    blk_kind_t mon_kind;
    block_t    mon_block;
    bit        mon_any;
    bit        mon_last;
    bit        in_burst;
    int        error_count;
    int        test_count;
    int        failed_tests;
    int        valid_count;
    int        expected_total;
    int        cycle_count;
    integer    seed;

    gcm_precompute_top #(
        .CTR_W        (CTR_W)
    ) DUT (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_req),
        .i_key        (i_key),
        .i_iv         (i_iv),
        .i_num_blocks (i_num_blocks),
        .o_ack        (o_ack),
        .o_valid      (o_valid),
        .o_kind       (o_kind),
        .o_block      (o_block)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------------------------------
    // handshake rules
    // --------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!i_arst_n) $rose(o_ack) |-> i_req)
    else
    begin
        error_count++;
        $display("handshake broken at %0t: o_ack rose while i_req was low", $time);
    end

    assert property (@(posedge clk) disable iff (!i_arst_n) (o_ack && i_req) |=> o_ack)
    else
    begin
        error_count++;
        $display("handshake broken at %0t: o_ack fell while i_req was high", $time);
    end

    assert property (@(posedge clk) disable iff (!i_arst_n) (o_ack && !i_req) |=> !o_ack)
    else
    begin
        error_count++;
        $display("handshake broken at %0t: o_ack stayed high after i_req went low", $time);
    end

    // --------------------------------------------------------------------------
    // output monitor, mid-cycle so the stage registers have settled
    // --------------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (i_arst_n && o_valid)
        begin
            valid_count++;
            if (exp_kind_q.size() == 0)
            begin
                error_count++;
                $display("output block at %0t arrived with no block outstanding", $time);
            end
            else
            begin
                mon_kind  = exp_kind_q.pop_front();
                mon_block = exp_block_q.pop_front();
                mon_any   = exp_any_q.pop_front();
                mon_last  = exp_last_q.pop_front();
                assert (o_kind == mon_kind)
                else
                begin
                    error_count++;
                    $display("[ERROR] %0t: kind %s, expected %s", $time, o_kind.name(),
                             mon_kind.name());
                end
                assert (mon_any || o_block == mon_block)
                else
                begin
                    error_count++;
                    $display("[ERROR] %0t: block %h, expected %h", $time, o_block, mon_block);
                end
                in_burst = !mon_last;
            end
        end
        else if (i_arst_n && in_burst)
        begin
            error_count++;
            $display("output stream broke off at %0t in the middle of an instance", $time);
            in_burst = 1'b0;
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles, the DUT did not finish in time", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_block(blk_kind_t kind, block_t value, bit any, bit last);
        exp_kind_q.push_back(kind);
        exp_block_q.push_back(value);
        exp_any_q.push_back(any);
        exp_last_q.push_back(last);
        expected_total++;
    endtask

    // full four-phase request, returns once o_ack is low again
    task automatic run_instance(key_t key, iv_t iv, int n, bit kat, int hold);
        expect_block(BLK_H, KAT_H, !kat, 1'b0);
        expect_block(BLK_J0, KAT_J0, !kat, n == 0);
        for (int i = 0; i < n; i++)
        begin
            expect_block(BLK_CB, KAT_CB2, !(kat && i == 0), i == n - 1);  // only ctr 2 known
        end
        i_req        = 1'b1;
        i_key        = key;
        i_iv         = iv;
        i_num_blocks = CTR_W'(n);
        while (!o_ack)
        begin
            next_drive_point();
        end
        repeat (hold + 1) next_drive_point();  // ack is taken at the next edge
        i_req = 1'b0;
        while (o_ack)
        begin
            next_drive_point();
        end
    endtask

    task automatic wait_drain();
        while (exp_kind_q.size() != 0)
        begin
            next_drive_point();
        end
        repeat (4) next_drive_point();  // room for stray blocks
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("test %0d %s: ok", test_count, name);
        end
        else
        begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    function automatic int rand_below(int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    function automatic key_t rand_key();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic iv_t rand_iv();
        return {$random(seed), $random(seed), $random(seed)};
    endfunction

    // --------------------------------------------------------------------------
    // test sequence
    // --------------------------------------------------------------------------
    initial
    begin
        int errs;
        seed           = 32'h8614bd0c;
        i_arst_n       = 1'b0;
        i_req          = 1'b0;
        i_key          = '0;
        i_iv           = '0;
        i_num_blocks   = '0;
        in_burst       = 1'b0;
        error_count    = 0;
        test_count     = 0;
        failed_tests   = 0;
        valid_count    = 0;
        expected_total = 0;
        repeat (8) @(posedge clk);
        #1;
        i_arst_n = 1'b1;

        errs = error_count;
        assert (!o_ack && !o_valid)
        else
        begin
            error_count++;
            $display("[ERROR] %0t: o_ack or o_valid high after reset", $time);
        end
        run_instance(rand_key(), rand_iv(), 3, 1'b0, 6);  // long req hold after ack
        wait_drain();
        finish_test("handshake", errs);

        errs = error_count;
        run_instance('0, '0, 1, 1'b1, 0);
        wait_drain();
        finish_test("known answer", errs);

        errs = error_count;
        for (int i = 0; i < 5; i++)
        begin
            run_instance(rand_key(), rand_iv(), (i == 0) ? 0 : rand_below(13), 1'b0,
                         rand_below(3));
            wait_drain();
        end
        finish_test("kind order and count", errs);

        errs = error_count;
        run_instance('0, '0, 2, 1'b1, rand_below(3));  // same key and IV as before
        wait_drain();
        finish_test("instance independence", errs);

        errs = error_count;
        for (int i = 0; i < 3; i++)
        begin
            run_instance(rand_key(), rand_iv(), rand_below(13), 1'b0, 0);
        end
        wait_drain();
        assert (valid_count == expected_total)
        else
        begin
            error_count++;
            $display("[ERROR] %0t: %0d output blocks seen, expected %0d", $time,
                     valid_count, expected_total);
        end
        finish_test("overlap", errs);

        $display("tests %0d, failed %0d, errors %0d, output blocks %0d", test_count,
                 failed_tests, error_count, valid_count);
        if (error_count == 0 && failed_tests == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
source/aes_pkg.sv
source/gcm_pkg.sv
source/aes_key_expand.sv
source/aes_round_stage.sv
source/gcm_block_counter.sv
source/gcm_precompute_ctrl.sv
source/gcm_precompute_top.sv
test/tb_gcm_precompute.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass or fail from the log

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_gcm_precompute -o sim_gcm > build.log 2>&1 &&
./obj_dir/sim_gcm > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q '\*\*\* FAILED \*\*\*' sim.log &&
{ echo "simulation failed, see sim.log"; exit 1; } ||
{ echo "simulation passed"; exit 0; }
